/* filelist.f */
source/bp_pkg.sv
source/bht.sv
source/btb.sv
source/branch_predictor.sv
dv/tb_branch_predictor.sv

/* run_sim.sh */
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_branch_predictor \
	-f filelist.f -o sim_branch_predictor
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_branch_predictor)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the run passes only if the pass line shows up on its own
if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

/* dv/bp_stimulus.txt */
# stall flush pc_cur r_valid r_pc r_target r_cf r_taken r_counter p_mispredict p_pc
# check (0 off, 1 valid and sel, 2 all) e_valid e_taken e_target e_cf e_counter e_sel
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 1 0 0 00000000 0 0 2
0 0 00001100 0 00000000 00000000 0 0 0 0 00000000 1 0 0 00000000 0 0 2
0 0 00002018 0 00000000 00000000 0 0 0 0 00000000 1 0 0 00000000 0 0 2
0 0 00001000 1 00001000 00004000 2 1 1 0 00000000 1 0 0 00000000 0 0 2
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00004000 2 1 1
0 0 00001100 0 00000000 00000000 0 0 0 0 00000000 1 0 0 00000000 0 0 2
0 0 00003008 1 00003008 00005000 1 1 1 0 00000000 1 0 0 00000000 0 0 2
0 0 00003008 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00005000 1 2 1
0 0 00003008 1 00003008 00005000 1 1 2 0 00000000 2 1 1 00005000 1 2 1
0 0 00003008 1 00003008 00005000 1 1 3 0 00000000 2 1 1 00005000 1 3 1
0 0 00003008 1 00003008 00005000 1 0 3 0 00000000 2 1 1 00005000 1 3 1
0 0 00003008 1 00003008 00005000 1 0 2 0 00000000 2 1 1 00005000 1 2 1
0 0 00003008 1 00003008 00005000 1 0 1 0 00000000 2 1 0 00005000 1 1 1
0 0 00003008 1 00003008 00005000 1 0 0 0 00000000 2 1 0 00005000 1 0 1
0 0 00003008 0 00000000 00000000 0 0 0 0 00000000 2 1 0 00005000 1 0 1
0 0 00001004 1 00001004 00006000 3 1 1 0 00000000 1 0 0 00000000 0 0 2
0 0 00001004 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00006000 3 1 2
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00004000 2 1 1
0 0 00002018 1 0000201c 00007000 2 1 1 0 00000000 1 0 0 00000000 0 0 2
0 0 00002018 0 00000000 00000000 0 0 0 0 00000000 2 0 1 00007000 2 1 2
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00004000 2 1 1
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00004000 2 1 1
1 0 00001000 1 00001000 00004400 2 1 1 0 00000000 2 1 1 00004000 2 1 1
1 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00004000 2 1 1
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00004400 2 1 1
0 1 00001000 0 00000000 00000000 0 0 0 0 00000000 2 0 1 00000000 0 0 2
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00004400 2 1 1
0 0 00001000 0 00000000 00000000 0 0 0 1 00001000 2 1 1 00004400 2 1 1
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00006000 3 1 2
0 0 00001000 1 00001004 00006600 3 1 1 1 00001004 2 1 1 00006000 3 1 2
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 1 1 00006600 3 1 2
0 0 00001000 0 00000000 00000000 0 0 0 1 00001004 2 1 1 00006600 3 1 2
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 2 0 1 00006600 0 1 2
0 0 00001000 0 00000000 00000000 0 0 0 0 00000000 0 0 0 00000000 0 0 0

/* dv/tb_branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_branch_predictor;

	import bp_pkg::*;

	localparam int clk_period = 100;
	localparam int reset_cycles = 10;
	localparam int n_fields = 18;
	localparam string stim_path = "dv/bp_stimulus.txt";

	// inputs for one cycle and the prediction expected in the cycle after
	typedef struct packed {
		logic              stall;
		logic              flush;
		virt_t             pc_cur;
		branch_resolved_t  resolved;
		presolved_branch_t presolved;
		logic [1:0]        chk;
		branch_predict_t   exp_pred;
		logic [1:0]        exp_sel;
	} stim_t;

	logic              clk;
	logic              rst;
	logic              stall;
	logic              flush;
	virt_t             pc_cur;
	virt_t             pc_prev;
	branch_resolved_t  resolved_branch;
	presolved_branch_t presolved_branch;
	branch_predict_t   prediction;
	logic [1:0]        prediction_sel;

	stim_t stim_q [$];
	int    error_count;
	int    check_count;
	logic  loaded;

	branch_predictor #(
		.size (64)
	) i_dut (
		.clk              (clk),
		.rst              (rst),
		.stall            (stall),
		.flush            (flush),
		.pc_cur           (pc_cur),
		.pc_prev          (pc_prev),
		.resolved_branch  (resolved_branch),
		.presolved_branch (presolved_branch),
		.prediction       (prediction),
		.prediction_sel   (prediction_sel)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	task automatic load_stimulus();
		int          fd;
		int          code;
		int          line_no;
		string       line_str;
		logic [31:0] f [n_fields];
		stim_t       s;
		fd = $fopen(stim_path, "r");
		if (fd == 0) begin
			$display("could not open the stimulus file %s", stim_path);
			error_count++;
		end else begin
			line_no = 0;
			while (!$feof(fd)) begin
				code = $fgets(line_str, fd);
				line_no++;
				// skip blank lines and the column notes
				if (code == 0 || line_str.len() < 2 || line_str[0] == "#") begin
					continue;
				end
				code = $sscanf(line_str,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
				if (code != n_fields) begin
					$display("stimulus line %0d is short, it holds %0d of %0d fields",
						line_no, code, n_fields);
					error_count++;
					continue;
				end
				s.stall                = f[0][0];
				s.flush                = f[1][0];
				s.pc_cur               = f[2];
				s.resolved.valid       = f[3][0];
				s.resolved.pc          = f[4];
				s.resolved.target      = f[5];
				s.resolved.cf          = cf_t'(f[6][1:0]);
				s.resolved.taken       = f[7][0];
				s.resolved.counter     = f[8][1:0];
				s.presolved.mispredict = f[9][0];
				s.presolved.pc         = f[10];
				s.chk                  = f[11][1:0];
				s.exp_pred.valid       = f[12][0];
				s.exp_pred.taken       = f[13][0];
				s.exp_pred.target      = f[14];
				s.exp_pred.cf          = cf_t'(f[15][1:0]);
				s.exp_pred.counter     = f[16][1:0];
				s.exp_sel              = f[17][1:0];
				stim_q.push_back(s);
			end
			$fclose(fd);
			if (stim_q.size() == 0) begin
				$display("the stimulus file %s holds no test lines", stim_path);
				error_count++;
			end
		end
	endtask

	// pc_prev trails pc_cur by one line as the fetch stage presents it
	task automatic drive_line(input stim_t s);
		pc_prev          = pc_cur;
		pc_cur           = s.pc_cur;
		stall            = s.stall;
		flush            = s.flush;
		resolved_branch  = s.resolved;
		presolved_branch = s.presolved;
	endtask

	task automatic compare_field(input int idx, input string name,
		input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: time %0t: entry %0d %s is %h, expected %h",
				$time, idx, name, got, exp);
			error_count++;
		end
	endtask

	// check flag 1 covers valid and the slot and flag 2 covers every field
	task automatic check_prediction(input stim_t s, input int idx);
		if (s.chk != 2'd0) begin
			check_count++;
			compare_field(idx, "valid", 32'(prediction.valid), 32'(s.exp_pred.valid));
			compare_field(idx, "prediction_sel", 32'(prediction_sel), 32'(s.exp_sel));
		end
		if (s.chk == 2'd2) begin
			compare_field(idx, "taken", 32'(prediction.taken), 32'(s.exp_pred.taken));
			compare_field(idx, "target", prediction.target, s.exp_pred.target);
			compare_field(idx, "cf", 32'(prediction.cf), 32'(s.exp_pred.cf));
			compare_field(idx, "counter", 32'(prediction.counter), 32'(s.exp_pred.counter));
		end
	endtask

	initial begin
		stim_t pending;
		stim_t idle;
		logic  have_pending;
		error_count      = 0;
		check_count      = 0;
		loaded           = 1'b0;
		have_pending     = 1'b0;
		rst              = 1'b1;
		stall            = 1'b0;
		flush            = 1'b0;
		pc_cur           = '0;
		pc_prev          = '0;
		resolved_branch  = '0;
		presolved_branch = '0;
		load_stimulus();
		loaded = 1'b1;

		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// outputs are read late in the cycle, once pc_prev names the pair just read
		foreach (stim_q[i]) begin
			if (i > 0) begin
				@(negedge clk);
			end
			drive_line(stim_q[i]);
			#(clk_period * 2 / 5);
			if (have_pending) begin
				check_prediction(pending, i - 1);
			end
			pending      = stim_q[i];
			have_pending = 1'b1;
		end

		// one quiet cycle brings out the last prediction
		@(negedge clk);
		idle        = '0;
		idle.pc_cur = pc_cur;
		drive_line(idle);
		#(clk_period * 2 / 5);
		if (have_pending) begin
			check_prediction(pending, stim_q.size() - 1);
		end
		if (check_count == 0) begin
			$display("no prediction was checked");
			error_count++;
		end

		$display("%0d checks run, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// the run needs one cycle per line plus reset and a little slack
	initial begin
		wait (loaded);
		#((stim_q.size() + 20) * clk_period);
		$display("timeout, the run did not end within %0d cycles", stim_q.size() + 20);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/branch_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_predictor #(
	parameter int size = bp_pkg::bp_entries
)(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      stall,
	input  logic                      flush,

	// word-aligned address being fetched now
	input  bp_pkg::virt_t             pc_cur,

	// address fetched one cycle earlier
	input  bp_pkg::virt_t             pc_prev,

	// outcome of a branch from execute
	input  bp_pkg::branch_resolved_t  resolved_branch,

	// false control flow found in decode
	input  bp_pkg::presolved_branch_t presolved_branch,

	// prediction for the pair at pc_prev
	output bp_pkg::branch_predict_t   prediction,
	output logic [1:0]                prediction_sel
);

	import bp_pkg::*;

	bht_update_t        bht_update;
	counter_t [1:0]     bht_predict;
	counter_t [1:0]     bht_predict_delay;

	btb_update_t        btb_update;
	btb_predict_t [1:0] btb_predict;
	btb_predict_t [1:0] btb_predict_delay;

	// read results the prediction is formed from
	counter_t [1:0]     bht_src;
	btb_predict_t [1:0] btb_src;

	logic               pipe_stall;
	logic               pipe_flush;
	logic               sel_idx;
	logic               line_end;
	btb_predict_t       btb_selected;
	counter_t           bht_selected;

	// only conditional branches train the counters
	assign bht_update.valid   = resolved_branch.valid && resolved_branch.cf == cf_branch;
	assign bht_update.pc      = resolved_branch.pc;
	assign bht_update.taken   = resolved_branch.taken;
	assign bht_update.counter = resolved_branch.counter;

	// any resolved control flow installs a target
	assign btb_update.valid  = resolved_branch.valid;
	assign btb_update.pc     = resolved_branch.pc;
	assign btb_update.target = resolved_branch.target;
	assign btb_update.cf     = resolved_branch.cf;

	bht #(
		.size (size)
	) i_bht (
		.clk     (clk),
		.rst     (rst),
		.vaddr   (pc_cur),
		.update  (bht_update),
		.predict (bht_predict)
	);

	btb #(
		.size (size)
	) i_btb (
		.clk              (clk),
		.rst              (rst),
		.vaddr            (pc_cur),
		.update           (btb_update),
		.presolved_branch (presolved_branch),
		.predict          (btb_predict)
	);

	// copy of the read results that freezes while fetch is stalled
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			bht_predict_delay <= '0;
			btb_predict_delay <= '0;
		end else if (!stall) begin
			bht_predict_delay <= bht_predict;
			btb_predict_delay <= btb_predict;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_stall <= 1'b0;
			pipe_flush <= 1'b0;
		end else begin
			pipe_stall <= stall;
			pipe_flush <= flush;
		end
	end

	// after a flush the cleared copy reads as no control flow and valid stays low
	assign bht_src = (pipe_stall || pipe_flush) ? bht_predict_delay : bht_predict;
	assign btb_src = (pipe_stall || pipe_flush) ? btb_predict_delay : btb_predict;

	// odd word fetched means only slot 1 is left in the pair
	assign sel_idx = pc_prev[2] || btb_src[0].cf == cf_none;

	// slot 1 of the last pair in a line has its delay slot in the next line
	assign line_end = &pc_prev[icache_offset_width-1:3];

	assign btb_selected = btb_src[sel_idx];
	assign bht_selected = bht_src[sel_idx];

	always_comb begin
		prediction_sel          = '0;
		prediction_sel[sel_idx] = 1'b1;

		prediction.valid   = btb_selected.cf != cf_none;
		prediction.target  = btb_selected.target;
		prediction.cf      = btb_selected.cf;
		prediction.counter = bht_selected;

		// jumps are always taken
		if (btb_selected.cf == cf_branch) begin
			prediction.taken = bht_selected[1];
		end else begin
			prediction.taken = 1'b1;
		end

		if (line_end && sel_idx) begin
			prediction.valid = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/btb.sv */
`timescale 1ns/10ps
`default_nettype none

module btb #(
	parameter int size = bp_pkg::bp_entries
)(
	input  logic                       clk,
	input  logic                       rst,

	// fetch address whose pair of words is looked up
	input  bp_pkg::virt_t              vaddr,

	// install from execute
	input  bp_pkg::btb_update_t        update,

	// invalidate from decode
	input  bp_pkg::presolved_branch_t  presolved_branch,

	// lookup results for the two slots
	output bp_pkg::btb_predict_t [1:0] predict
);

	import bp_pkg::*;

	localparam int bank_entries = size / 2;
	localparam int idx_w = $clog2(bank_entries);
	localparam int tag_w = 32 - 3 - idx_w;

	typedef struct packed {
		logic [tag_w-1:0] tag;
		virt_t            target;
		cf_t              cf;
	} entry_t;

	// valid bits are kept apart from the tag, target and cf
	logic   valid_mem [2][bank_entries];
	entry_t entry_mem [2][bank_entries];

	logic [idx_w-1:0] rd_idx;
	logic [idx_w-1:0] upd_idx;
	logic [idx_w-1:0] inv_idx;
	logic [tag_w-1:0] rd_tag;
	logic [tag_w-1:0] upd_tag;
	entry_t           upd_entry;

	// registered read side
	logic [1:0]       rd_valid_q;
	entry_t           rd_entry_q [2];
	logic [tag_w-1:0] rd_tag_q;

	assign rd_idx  = vaddr[idx_w+2:3];
	assign rd_tag  = vaddr[31:idx_w+3];
	assign upd_idx = update.pc[idx_w+2:3];
	assign upd_tag = update.pc[31:idx_w+3];
	assign inv_idx = presolved_branch.pc[idx_w+2:3];

	assign upd_entry.tag    = upd_tag;
	assign upd_entry.target = update.target;
	assign upd_entry.cf     = update.cf;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int b = 0; b < 2; b++) begin
				for (int i = 0; i < bank_entries; i++) begin
					valid_mem[b][i] <= 1'b0;
				end
			end
			rd_valid_q <= '0;
		end else begin
			if (presolved_branch.mispredict) begin
				valid_mem[presolved_branch.pc[2]][inv_idx] <= 1'b0;
			end
			// the later assignment wins and lets an install beat the invalidate
			if (update.valid) begin
				valid_mem[update.pc[2]][upd_idx] <= 1'b1;
			end
			for (int b = 0; b < 2; b++) begin
				rd_valid_q[b] <= valid_mem[b][rd_idx];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (update.valid) begin
			entry_mem[update.pc[2]][upd_idx] <= upd_entry;
		end
		for (int b = 0; b < 2; b++) begin
			rd_entry_q[b] <= entry_mem[b][rd_idx];
		end
		rd_tag_q <= rd_tag;
	end

	// an empty entry or a tag from another address reads as no control flow
	always_comb begin
		for (int b = 0; b < 2; b++) begin
			predict[b].target = rd_entry_q[b].target;
			if (rd_valid_q[b] && rd_entry_q[b].tag == rd_tag_q) begin
				predict[b].cf = rd_entry_q[b].cf;
			end else begin
				predict[b].cf = cf_none;
			end
		end
	end

endmodule

`default_nettype wire

/* source/bht.sv */
`timescale 1ns/10ps
`default_nettype none

module bht #(
	parameter int size = bp_pkg::bp_entries
)(
	input  logic                   clk,
	input  logic                   rst,

	// fetch address whose pair of words is read
	input  bp_pkg::virt_t          vaddr,

	// counter write-back from execute
	input  bp_pkg::bht_update_t    update,

	// registered counters for the two slots
	output bp_pkg::counter_t [1:0] predict
);

	import bp_pkg::*;

	localparam int bank_entries = size / 2;
	localparam int idx_w = $clog2(bank_entries);

	// bank 0 holds the even words of each pair, bank 1 the odd words
	counter_t cnt_mem [2][bank_entries];

	logic [idx_w-1:0] rd_idx;
	logic [idx_w-1:0] upd_idx;
	counter_t         upd_counter;

	// index sits just above the word-in-pair bit
	assign rd_idx  = vaddr[idx_w+2:3];
	assign upd_idx = update.pc[idx_w+2:3];

	// step the counter that was predicted, not the one in the table now
	assign upd_counter = counter_next(update.counter, update.taken);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int b = 0; b < 2; b++) begin
				for (int i = 0; i < bank_entries; i++) begin
					cnt_mem[b][i] <= counter_init;
				end
			end
			predict <= {2{counter_init}};
		end else begin
			if (update.valid) begin
				cnt_mem[update.pc[2]][upd_idx] <= upd_counter;
			end

			// the read sees the old contents on a same-edge write
			for (int b = 0; b < 2; b++) begin
				predict[b] <= cnt_mem[b][rd_idx];
			end
		end
	end

endmodule

`default_nettype wire

/* source/bp_pkg.sv */
`default_nettype none

package bp_pkg;

	// default entries per table over both banks
	localparam int bp_entries = 4096;

	// instruction cache line size in bits
	localparam int icache_line_width = 256;

	// byte offset bits within one cache line
	localparam int icache_offset_width = $clog2(icache_line_width / 8);

	// word-aligned 32-bit virtual fetch address
	typedef logic [31:0] virt_t;

	// kinds of control flow an instruction can carry
	typedef enum logic [1:0] {
		cf_none     = 2'd0,
		cf_branch   = 2'd1,
		cf_jump     = 2'd2,
		cf_jump_reg = 2'd3
	} cf_t;

	// 2-bit saturating counter whose upper bit means predict taken
	typedef logic [1:0] counter_t;

	// counters start out weakly not taken
	localparam counter_t counter_init = 2'b01;

	// branch outcome coming back from execute
	typedef struct packed {
		logic     valid;
		virt_t    pc;
		virt_t    target;
		cf_t      cf;
		logic     taken;
		counter_t counter;
	} branch_resolved_t;

	// decode found that a predicted address holds no control flow
	typedef struct packed {
		logic  mispredict;
		virt_t pc;
	} presolved_branch_t;

	// prediction handed to the fetch stage
	typedef struct packed {
		logic     valid;
		logic     taken;
		virt_t    target;
		cf_t      cf;
		counter_t counter;
	} branch_predict_t;

	typedef struct packed {
		logic     valid;
		virt_t    pc;
		logic     taken;
		counter_t counter;
	} bht_update_t;

	typedef struct packed {
		logic  valid;
		virt_t pc;
		virt_t target;
		cf_t   cf;
	} btb_update_t;

	// one slot of a target buffer read
	typedef struct packed {
		cf_t   cf;
		virt_t target;
	} btb_predict_t;

	// move a counter one step toward the outcome and saturate at both ends
	function automatic counter_t counter_next(counter_t cnt, logic taken);
		counter_t res;
		res = cnt;
		if (taken && cnt != 2'b11) begin
			res = cnt + 2'd1;
		end else if (!taken && cnt != 2'b00) begin
			res = cnt - 2'd1;
		end
		return res;
	endfunction

endpackage

`default_nettype wire
